/* conv_patterns.hex */
// Weights: 36 bytes, bank 0 then bank 1, slot (row*3 + col)*2 + channel
// Input row: last flag byte, then 16 pixel bytes at slot col*2 + channel
// Rows 2 and 3 of each image are followed by 12 expected bytes at slot col*2 + out channel
// Weight bank 0
10 10 20 10 30 10 10 10 20 10 30 10 10 10 20 10 30 10
// Weight bank 1
10 08 10 08 10 08 20 08 20 08 20 08 30 08 30 08 30 08
// Image 1
00 10 51 11 53 12 55 13 57 14 59 15 5B 16 5D 17 5F
00 20 63 21 65 22 67 23 69 24 6B 25 6D 26 6F 27 71
00 30 75 31 77 32 79 33 7B 34 7D 35 7F 36 81 37 83
E5 74 09 8F 2D AA 51 C5 75 E0 99 FB
01 40 87 41 89 42 8B 43 8D 44 8F 45 91 46 93 47 95
A7 E5 CB 00 EF 1B 13 36 37 51 5B 6C
// Image 2
00 05 0B 06 0D 07 0F 08 11 09 13 0A 15 0B 17 0C 19
00 47 C1 48 C3 49 C5 4A C7 4B C9 4C CB 4D CD 4E CF
00 22 3D 23 3F 24 41 25 43 26 45 27 47 28 49 29 4B
D9 8F FD AA 21 C5 45 E0 69 FB 8D 16
01 90 99 91 9B 92 9D 93 9F 94 A1 95 A3 96 A5 97 A7
C5 2A E9 45 0D 60 31 7B 55 96 79 B1

/* conv_row.f */
+incdir+.
conv_types_pkg.sv
conv_ctrl_pkg.sv
conv_step_if.sv
row_window_buffer.sv
conv_sequencer.sv
kernel_mac.sv
output_row_assembler.sv
conv_row_top.sv
conv_tb.sv

/* Makefile */
# Verilator build for the conv_row engine

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= conv_row.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= sim passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int IMAGES         = 2;
    localparam int ROWS_PER_IMAGE = 4;
    localparam int ROWS           = IMAGES * ROWS_PER_IMAGE;
    localparam int OUT_ROWS       = IMAGES * (ROWS_PER_IMAGE - `CONV_KERNEL_SIZE + 1);
    localparam int STEPS          = `CONV_OUT_WIDTH * `CONV_OUT_CHANNELS;
    localparam int WEIGHT_BYTES   = `CONV_OUT_CHANNELS * `CONV_BANK_BITS / 8;
    localparam int IN_BYTES       = `CONV_IN_ROW_BITS / 8;
    localparam int OUT_BYTES      = `CONV_OUT_ROW_BITS / 8;
    localparam int PAT_BYTES      = WEIGHT_BYTES + ROWS * (1 + IN_BYTES) + OUT_ROWS * OUT_BYTES;
    localparam int TIMEOUT_CYCLES = ROWS * (STEPS + `CONV_IN_WIDTH + 10) + 50;

    logic                        clock_i = 1'b0;
    logic                        reset_i;
    conv_types_pkg::in_row_t     in_row_i;
    logic                        in_row_valid_i;
    logic                        in_row_last_i;
    logic                        in_row_accept_o;
    conv_types_pkg::weight_set_t weights_i;
    conv_types_pkg::out_row_t    out_row_o;
    logic                        out_row_valid_o;
    logic                        out_row_last_o;
    logic                        out_row_accept_i;

    logic [7:0]               pat_mem [0:PAT_BYTES-1];
    conv_types_pkg::out_row_t exp_row_q [$];
    logic                     exp_last_q [$];
    int                       errors    = 0;
    int                       checks    = 0;
    int                       rows_read = 0;
    integer                   seed      = 32'hb93c_d9ca;

    conv_row_top DUT (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_i         (in_row_i),
        .in_row_valid_i   (in_row_valid_i),
        .in_row_last_i    (in_row_last_i),
        .in_row_accept_o  (in_row_accept_o),
        .weights_i        (weights_i),
        .out_row_o        (out_row_o),
        .out_row_valid_o  (out_row_valid_o),
        .out_row_last_o   (out_row_last_o),
        .out_row_accept_i (out_row_accept_i)
    );

    initial begin : clock_gen
        forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
    end

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Engine must stay quiet, no output row and no row taken
    task automatic idle_and_check(input int cycles);
        repeat (cycles) begin
            @(negedge clock_i);
            checks++;
            if (out_row_valid_o !== 1'b0 || in_row_accept_o !== 1'b0) begin
                errors++;
                $display("Output valid or input accept rose while the engine should be idle");
            end
        end
    endtask

    // Hold the row until the engine takes it
    task automatic send_row(input conv_types_pkg::in_row_t row, input logic last);
        logic taken;
        taken          = 1'b0;
        in_row_i       = row;
        in_row_last_i  = last;
        in_row_valid_i = 1'b1;
        while (!taken) begin
            #(CLK_PERIOD / 4);
            taken = in_row_accept_o;
            if (taken && (out_row_valid_o || exp_row_q.size() != 0)) begin
                errors++;
                $display("Input row accepted while an output row was still pending");
            end
            @(negedge clock_i);
        end
        in_row_valid_i = 1'b0;
    endtask

    task automatic check_row(input conv_types_pkg::out_row_t got_row, input logic got_last);
        conv_types_pkg::out_row_t want_row;
        logic                     want_last;
        checks++;
        if (exp_row_q.size() == 0) begin
            errors++;
            $display("Output row came out before a full window was taken in");
        end else begin
            want_row  = exp_row_q.pop_front();
            want_last = exp_last_q.pop_front();
            if (got_row !== want_row) begin
                errors++;
                $display("Fail out_row_o: expected %h, actual %h", want_row, got_row);
            end
            if (got_last !== want_last) begin
                errors++;
                $display("Fail out_row_last_o: expected %h, actual %h", want_last, got_last);
            end
        end
    endtask

    initial begin : stimulus
        conv_types_pkg::in_row_t  row;
        conv_types_pkg::out_row_t want;
        logic                     last;
        int                       ptr;
        in_row_i       = '0;
        in_row_valid_i = 1'b0;
        in_row_last_i  = 1'b0;
        weights_i      = '0;
        reset_i        = 1'b1;
        $readmemh("conv_patterns.hex", pat_mem);
        for (int i = 0; i < WEIGHT_BYTES; i++) begin
            weights_i[i*8 +: 8] = pat_mem[i];
        end
        repeat (RESET_CYCLES) @(negedge clock_i);
        reset_i = 1'b0;
        idle_and_check(10);

        ptr = WEIGHT_BYTES;
        for (int img = 0; img < IMAGES; img++) begin
            for (int r = 0; r < ROWS_PER_IMAGE; r++) begin
                last = pat_mem[ptr][0];
                for (int i = 0; i < IN_BYTES; i++) begin
                    row[i*8 +: 8] = pat_mem[ptr + 1 + i];
                end
                ptr = ptr + 1 + IN_BYTES;
                send_row(row, last);
                if (r >= `CONV_KERNEL_SIZE - 1) begin
                    for (int i = 0; i < OUT_BYTES; i++) begin
                        want[i*8 +: 8] = pat_mem[ptr + i];
                    end
                    ptr = ptr + OUT_BYTES;
                    exp_row_q.push_back(want);
                    exp_last_q.push_back(last);
                end else if (r == `CONV_KERNEL_SIZE - 2) begin
                    // Window not full yet
                    idle_and_check(STEPS + 4);
                end
            end
        end

        while (rows_read < OUT_ROWS) @(negedge clock_i);
        idle_and_check(STEPS + 4);
        finish_run();
    end

    // Output side with a random accept delay
    initial begin : consumer
        conv_types_pkg::out_row_t held_row;
        logic                     held_last;
        int                       delay;
        out_row_accept_i = 1'b0;
        forever begin
            @(negedge clock_i);
            out_row_accept_i = 1'b0;
            if (!reset_i && out_row_valid_o) begin
                held_row  = out_row_o;
                held_last = out_row_last_o;
                check_row(held_row, held_last);
                delay = $unsigned($random(seed)) % 4;
                for (int d = 0; d < delay; d++) begin
                    @(negedge clock_i);
                    checks++;
                    if (out_row_valid_o !== 1'b1) begin
                        errors++;
                        $display("Output valid dropped before the row was accepted");
                    end
                    if (out_row_o !== held_row) begin
                        errors++;
                        $display("Fail out_row_o: expected %h, actual %h", held_row, out_row_o);
                    end
                end
                out_row_accept_i = 1'b1;
                rows_read++;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clock_i);
        errors++;
        $display("Timeout after %0d cycles, the engine stopped responding", TIMEOUT_CYCLES);
        finish_run();
    end

endmodule

`default_nettype wire

/* conv_row_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_row_top (
    input  wire                              clock_i,
    input  wire                              reset_i,
    input  wire conv_types_pkg::in_row_t     in_row_i,
    input  wire                              in_row_valid_i,
    input  wire                              in_row_last_i,
    output logic                             in_row_accept_o,
    input  wire conv_types_pkg::weight_set_t weights_i,
    output conv_types_pkg::out_row_t         out_row_o,
    output logic                             out_row_valid_o,
    output logic                             out_row_last_o,
    input  wire                              out_row_accept_i
);

    conv_types_pkg::window_t window;
    logic                    shift_vert;
    logic                    shift_horiz;
    logic                    row_free;

    conv_step_if step_bus ();

    // Decode
    row_window_buffer u_buffer (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .row_i         (in_row_i),
        .shift_vert_i  (shift_vert),
        .shift_horiz_i (shift_horiz),
        .window_o      (window)
    );

    conv_sequencer u_sequencer (
        .clock_i         (clock_i),
        .reset_i         (reset_i),
        .in_row_valid_i  (in_row_valid_i),
        .in_row_last_i   (in_row_last_i),
        .in_row_accept_o (in_row_accept_o),
        .row_free_i      (row_free),
        .shift_vert_o    (shift_vert),
        .shift_horiz_o   (shift_horiz),
        .step            (step_bus.seq)
    );

    // Execute
    kernel_mac u_mac (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .window_i  (window),
        .weights_i (weights_i),
        .step      (step_bus.mac)
    );

    // Result
    output_row_assembler u_assembler (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .step             (step_bus.asm),
        .row_free_o       (row_free),
        .out_row_o        (out_row_o),
        .out_row_valid_o  (out_row_valid_o),
        .out_row_last_o   (out_row_last_o),
        .out_row_accept_i (out_row_accept_i)
    );

endmodule

`default_nettype wire

/* output_row_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module output_row_assembler (
    input  wire                      clock_i,
    input  wire                      reset_i,
    conv_step_if.asm                 step,
    output logic                     row_free_o,
    output conv_types_pkg::out_row_t out_row_o,
    output logic                     out_row_valid_o,
    output logic                     out_row_last_o,
    input  wire                      out_row_accept_i
);

    localparam int VB = `CONV_VALUE_BITS;

    conv_types_pkg::out_row_t out_row_q;
    logic                     out_valid_q;
    logic                     out_last_q;

    // Each result lands in its (column, channel) slot
    always_ff @(posedge clock_i) begin
        if (step.res_valid) begin
            out_row_q[(step.res_col*`CONV_OUT_CHANNELS + step.res_och)*VB +: VB] <=
                step.res_value;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end else if (step.res_valid && step.res_final) begin
            out_valid_q <= 1'b1;
            out_last_q  <= step.res_last;
        end else if (out_valid_q && out_row_accept_i) begin
            out_valid_q <= 1'b0;
            out_last_q  <= 1'b0;
        end
    end

    assign out_row_o       = out_row_q;
    assign out_row_valid_o = out_valid_q;
    assign out_row_last_o  = out_last_q;

    // Free once the row is read and the pipeline is empty
    assign row_free_o = !out_valid_q && !step.issue_valid && !step.res_valid;

    // Row and valid hold until the consumer takes them
    out_row_held: assert property (
        @(posedge clock_i) disable iff (reset_i)
        out_row_valid_o && !out_row_accept_i |=> out_row_valid_o && $stable(out_row_o)
    );

endmodule

`default_nettype wire

/* kernel_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module kernel_mac (
    input  wire                           clock_i,
    input  wire                           reset_i,
    input  wire conv_types_pkg::window_t     window_i,
    input  wire conv_types_pkg::weight_set_t weights_i,
    conv_step_if.mac                      step
);

    localparam int VB = `CONV_VALUE_BITS;
    localparam int WB = `CONV_WEIGHT_BITS;
    localparam int BB = `CONV_BANK_BITS;

    conv_types_pkg::kernel_bank_t bank;
    conv_types_pkg::acc_t         prod;
    conv_types_pkg::acc_t         sum;

    // Dot product of the window with the selected bank
    always_comb begin
        bank = weights_i[step.issue_och*BB +: BB];
        sum  = '0;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            prod = conv_types_pkg::acc_t'(conv_types_pkg::pixel_t'(window_i[i*VB +: VB]))
                 * conv_types_pkg::acc_t'(conv_types_pkg::weight_t'(bank[i*WB +: WB]));
            sum  = sum + (prod >> `CONV_WEIGHT_Q_SHIFT);
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            step.res_valid <= 1'b0;
        end else begin
            step.res_valid <= step.issue_valid;
        end
    end

    // Result payload keeps only the low bits of the sum
    always_ff @(posedge clock_i) begin
        if (step.issue_valid) begin
            step.res_value <= sum[VB-1:0];
            step.res_col   <= step.issue_col;
            step.res_och   <= step.issue_och;
            step.res_final <= step.issue_final;
            step.res_last  <= step.issue_last;
        end
    end

    // Steps of one row reach the MAC back to back
    steps_back_to_back: assert property (
        @(posedge clock_i) disable iff (reset_i)
        step.res_valid && !step.res_final |-> step.issue_valid
    );

endmodule

`default_nettype wire

/* conv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_sequencer (
    input  wire       clock_i,
    input  wire       reset_i,
    input  wire       in_row_valid_i,
    input  wire       in_row_last_i,
    output logic      in_row_accept_o,
    input  wire       row_free_i,
    output logic      shift_vert_o,
    output logic      shift_horiz_o,
    conv_step_if.seq  step
);

    localparam int CNT_BITS = $clog2(`CONV_KERNEL_SIZE + 1);

    localparam logic [CNT_BITS-1:0] ROWS_FULL  = CNT_BITS'(`CONV_KERNEL_SIZE);
    localparam logic [CNT_BITS-1:0] ROWS_READY = CNT_BITS'(`CONV_KERNEL_SIZE - 1);

    localparam conv_ctrl_pkg::col_idx_t LAST_COL =
        conv_ctrl_pkg::col_idx_t'(`CONV_OUT_WIDTH - 1);
    localparam conv_ctrl_pkg::col_idx_t LAST_ROT =
        conv_ctrl_pkg::col_idx_t'(`CONV_KERNEL_SIZE - 2);
    localparam conv_ctrl_pkg::och_idx_t LAST_OCH =
        conv_ctrl_pkg::och_idx_t'(`CONV_OUT_CHANNELS - 1);

    conv_ctrl_pkg::seq_state_t state_q;
    logic [CNT_BITS-1:0]       rows_held_q;
    logic                      last_q;
    conv_ctrl_pkg::col_idx_t   col_q;
    conv_ctrl_pkg::och_idx_t   och_q;
    logic                      col_done;

    assign in_row_accept_o = (state_q == conv_ctrl_pkg::S_TAKE_ROW)
                             && in_row_valid_i && row_free_i;
    assign shift_vert_o    = in_row_accept_o;

    // Window moves on after the last channel of each column
    assign col_done      = (state_q == conv_ctrl_pkg::S_COMPUTE) && (och_q == LAST_OCH);
    assign shift_horiz_o = col_done || (state_q == conv_ctrl_pkg::S_ROTATE);

    assign step.issue_valid = (state_q == conv_ctrl_pkg::S_COMPUTE);
    assign step.issue_col   = col_q;
    assign step.issue_och   = och_q;
    assign step.issue_final = col_done && (col_q == LAST_COL);
    assign step.issue_last  = last_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q     <= conv_ctrl_pkg::S_TAKE_ROW;
            rows_held_q <= '0;
            last_q      <= 1'b0;
            col_q       <= '0;
            och_q       <= '0;
        end else begin
            case (state_q)
                conv_ctrl_pkg::S_TAKE_ROW: begin
                    if (in_row_accept_o) begin
                        last_q <= in_row_last_i;
                        col_q  <= '0;
                        och_q  <= '0;
                        if (rows_held_q >= ROWS_READY) begin
                            state_q <= conv_ctrl_pkg::S_COMPUTE;
                            if (rows_held_q != ROWS_FULL) begin
                                rows_held_q <= rows_held_q + 1'b1;
                            end
                        end else if (in_row_last_i) begin
                            // Short image has nothing to compute
                            rows_held_q <= '0;
                        end else begin
                            rows_held_q <= rows_held_q + 1'b1;
                        end
                    end
                end
                conv_ctrl_pkg::S_COMPUTE: begin
                    if (col_done) begin
                        och_q <= '0;
                        if (col_q == LAST_COL) begin
                            col_q   <= '0;
                            state_q <= conv_ctrl_pkg::S_ROTATE;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        och_q <= och_q + 1'b1;
                    end
                end
                conv_ctrl_pkg::S_ROTATE: begin
                    // col_q counts the remaining turns back to column 0
                    if (col_q == LAST_ROT) begin
                        col_q   <= '0;
                        state_q <= conv_ctrl_pkg::S_DRAIN;
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                conv_ctrl_pkg::S_DRAIN: begin
                    // Wait for the output row to be read
                    if (row_free_i) begin
                        state_q <= conv_ctrl_pkg::S_TAKE_ROW;
                        if (last_q) begin
                            rows_held_q <= '0;
                        end
                    end
                end
                default: state_q <= conv_ctrl_pkg::S_TAKE_ROW;
            endcase
        end
    end

    // A row that fills the window starts the run at column 0 and channel 0
    full_window_starts_run: assert property (
        @(posedge clock_i) disable iff (reset_i)
        in_row_accept_o && (rows_held_q >= ROWS_READY) |=>
            step.issue_valid && (step.issue_col == '0) && (step.issue_och == '0)
    );

endmodule

`default_nettype wire

/* row_window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module row_window_buffer (
    input  wire                     clock_i,
    input  wire                     reset_i,
    input  wire conv_types_pkg::in_row_t row_i,
    input  wire                     shift_vert_i,
    input  wire                     shift_horiz_i,
    output conv_types_pkg::window_t window_o
);

    localparam int K  = `CONV_KERNEL_SIZE;
    localparam int PB = `CONV_PIXEL_BITS;
    localparam int RB = `CONV_IN_ROW_BITS;

    // Index 0 holds the oldest row, K-1 the newest
    conv_types_pkg::in_row_t rows_q [K];

    always_ff @(posedge clock_i) begin
        if (shift_vert_i) begin
            for (int r = 0; r < K - 1; r++) begin
                rows_q[r] <= rows_q[r + 1];
            end
            rows_q[K - 1] <= row_i;
        end else if (shift_horiz_i) begin
            // Rotate left by one pixel, column 0 wraps to the far end
            for (int r = 0; r < K; r++) begin
                rows_q[r] <= {rows_q[r][PB-1:0], rows_q[r][RB-1:PB]};
            end
        end
    end

    // Window is the first K columns of every held row
    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                window_o[(r*K + c)*PB +: PB] = rows_q[r][c*PB +: PB];
            end
        end
    end

    // Sequencer must never load a row during a rotation
    shifts_exclusive: assert property (
        @(posedge clock_i) disable iff (reset_i)
        !(shift_vert_i && shift_horiz_i)
    );

endmodule

`default_nettype wire

/* conv_step_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface conv_step_if;

    // Issue stage, one step per cycle from the sequencer
    logic                    issue_valid;
    conv_ctrl_pkg::col_idx_t issue_col;
    conv_ctrl_pkg::och_idx_t issue_och;
    logic                    issue_final;
    logic                    issue_last;

    // Result stage, issue fields one cycle later plus the sum
    logic                    res_valid;
    conv_types_pkg::pixel_t  res_value;
    conv_ctrl_pkg::col_idx_t res_col;
    conv_ctrl_pkg::och_idx_t res_och;
    logic                    res_final;
    logic                    res_last;

    modport seq (
        output issue_valid, issue_col, issue_och, issue_final, issue_last
    );

    modport mac (
        input  issue_valid, issue_col, issue_och, issue_final, issue_last,
        output res_valid, res_value, res_col, res_och, res_final, res_last
    );

    // Assembler also watches the issue valid to know when steps are in flight
    modport asm (
        input issue_valid,
        input res_valid, res_value, res_col, res_och, res_final, res_last
    );

endinterface

`default_nettype wire

/* conv_ctrl_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        S_TAKE_ROW,
        S_COMPUTE,
        S_ROTATE,
        S_DRAIN
    } seq_state_t;

    // Column position inside a row
    typedef logic [$clog2(`CONV_IN_WIDTH)-1:0] col_idx_t;

    // Output channel of the current step
    typedef logic [$clog2(`CONV_OUT_CHANNELS)-1:0] och_idx_t;

endpackage

`default_nettype wire

/* conv_types_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_types_pkg;

    // Scalars
    typedef logic [`CONV_VALUE_BITS-1:0] pixel_t;
    typedef logic [`CONV_WEIGHT_BITS-1:0] weight_t;

    // Running sum, wide enough for one shifted product
    typedef logic [`CONV_ACC_BITS-1:0] acc_t;

    // One input row, pixel (col, ch) at slot col*IN_CHANNELS + ch
    typedef logic [`CONV_IN_ROW_BITS-1:0] in_row_t;

    // One output row, result (col, och) at slot col*OUT_CHANNELS + och
    typedef logic [`CONV_OUT_ROW_BITS-1:0] out_row_t;

    // Window taps, slot (row*KERNEL_SIZE + col)*IN_CHANNELS + ch
    // Row 0 is the oldest row
    typedef logic [`CONV_WINDOW_BITS-1:0] window_t;

    // Weights for one output channel, same slot order as window_t
    typedef logic [`CONV_BANK_BITS-1:0] kernel_bank_t;

    // All banks, bank for output channel o at o*BANK_BITS
    typedef logic [`CONV_OUT_CHANNELS*`CONV_BANK_BITS-1:0] weight_set_t;

endpackage

`default_nettype wire

/* conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Window geometry
`define CONV_KERNEL_SIZE     3
`define CONV_IN_WIDTH        8
`define CONV_OUT_WIDTH       (`CONV_IN_WIDTH - `CONV_KERNEL_SIZE + 1)
`define CONV_IN_CHANNELS     2
`define CONV_OUT_CHANNELS    2

// Fixed-point format, values and weights unsigned
`define CONV_VALUE_BITS      8
`define CONV_WEIGHT_BITS     8
`define CONV_WEIGHT_Q_SHIFT  4
`define CONV_ACC_BITS        16

// Sizes of the flat vectors, channel varies fastest everywhere
`define CONV_PIXEL_BITS      (`CONV_IN_CHANNELS * `CONV_VALUE_BITS)
`define CONV_TAPS            (`CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE * `CONV_IN_CHANNELS)
`define CONV_IN_ROW_BITS     (`CONV_IN_WIDTH * `CONV_PIXEL_BITS)
`define CONV_OUT_ROW_BITS    (`CONV_OUT_WIDTH * `CONV_OUT_CHANNELS * `CONV_VALUE_BITS)
`define CONV_WINDOW_BITS     (`CONV_TAPS * `CONV_VALUE_BITS)
`define CONV_BANK_BITS       (`CONV_TAPS * `CONV_WEIGHT_BITS)

`endif
